// File: verification/periph_cases.txt
# op addr data expected err, all hex; W write, R read, P set pins, S wait data cycles
# S compares the port in the addr column: 0 gpio_out 1 gpio_dir 2 irq 3 boot_addr 4 pad_mux
S 3 0 00008000 0
S 0 0 00000000 0
S 1 0 00000000 0
S 4 0 00000000 0
S 2 0 00000000 0
R 300 0 00008000 0
W 000 a5a50f0f 0 0
R 000 0 a5a50f0f 0
S 1 0 a5a50f0f 0
W 008 12345678 0 0
R 008 0 12345678 0
S 0 0 12345678 0
W 304 cafe0001 0 0
R 304 0 cafe0001 0
S 4 0 cafe0001 0
W 300 00001000 0 0
R 300 0 00001000 0
S 3 0 00001000 0
R 500 0 00000000 1
W 500 deadbeef 0 1
R 014 0 00000000 1
W 014 00001234 0 1
R 000 0 a5a50f0f 0
R 008 0 12345678 0
P 0 00000000 0 0
W 00c 00000020 0 0
P 0 00000020 0 0
S 2 4 00000000 0
R 004 0 00000020 0
R 204 0 00000001 0
W 200 00000001 0 0
S 2 1 00000001 0
R 010 0 00000020 0
R 010 0 00000000 0
W 204 00000001 0 0
R 204 0 00000000 0
W 200 00000003 0 0
W 108 0000000a 0 0
W 104 00000001 0 0
S 2 14 00000002 0
R 204 0 00000002 0
W 104 00000000 0 0
W 204 00000002 0 0
S 2 1 00000000 0
R 204 0 00000000 0

// File: sim.f
design/periph_pkg.sv
design/apb_if.sv
design/apb_decoder.sv
design/apb_gpio.sv
design/apb_timer.sv
design/apb_event_unit.sv
design/apb_soc_ctrl.sv
design/periph_top.sv
verification/tb_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build tb_periph with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_periph -f sim.f -o sim_periph \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_periph > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verification/tb_periph.sv
// testbench for the APB peripheral subsystem
`default_nettype none

module tb_periph;
  timeunit 1ns;
  timeprecision 100ps;
  import periph_pkg::*;

  localparam int MAX_CASES   = 128;
  localparam int N_RAND      = 4;    // random pairs per target register
  localparam int PREADY_WAIT = 16;   // access cycles before giving up

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////
  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  apb_addr_t             paddr_i;
  apb_data_t             pwdata_i;
  apb_data_t             prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic [GPIO_WIDTH-1:0] gpio_in_i;
  logic [GPIO_WIDTH-1:0] gpio_out_o;
  logic [GPIO_WIDTH-1:0] gpio_dir_o;
  logic [NUM_EVENTS-1:0] irq_o;
  apb_data_t             boot_addr_o;
  apb_data_t             pad_mux_o;

  // cases from the file
  logic [7:0]  case_op      [MAX_CASES];
  logic [31:0] case_addr    [MAX_CASES];  // port selector for S
  logic [31:0] case_data    [MAX_CASES];  // wait cycles for S
  logic [31:0] case_exp     [MAX_CASES];
  logic        case_err_exp [MAX_CASES];

  int     n_cases     = 0;
  int     n_pass      = 0;
  int     n_fail      = 0;
  int     load_err    = 0;
  int     case_err    = 0;    // errors in the running case
  int     cycles      = 0;
  int     cycle_limit = 200;  // raised once the cases are loaded
  integer seed        = 32'ha8c90384;

  periph_top i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .gpio_in_i   (gpio_in_i),
    .gpio_out_o  (gpio_out_o),
    .gpio_dir_o  (gpio_dir_o),
    .irq_o       (irq_o),
    .boot_addr_o (boot_addr_o),
    .pad_mux_o   (pad_mux_o)
  );

  always #50 clk_i = ~clk_i;   // 100 ns period

  // watchdog
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus access and bookkeeping
  ////////////////////////////////////////////////////////////
  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    waits = 0;
    @(negedge clk_i);             // setup phase
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr[APB_ADDR_WIDTH-1:0];
    pwdata_i  = wdata;
    @(negedge clk_i);             // access phase
    penable_i = 1'b1;
    #10;
    while (!pready_o && waits < PREADY_WAIT) begin
      @(negedge clk_i);
      #10;
      waits++;
    end
    if (!pready_o) begin
      $display("error at %0t: pready stayed low for %0d cycles", $time, PREADY_WAIT);
      case_err++;
    end
    rdata = prdata_o;             // sampled mid low phase
    err   = pslverr_o;
    @(negedge clk_i);             // access ends on the rising edge before
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic record_result(input int idx, input string label);
    if (case_err == 0) begin
      n_pass++;
      $display("case %0d %s ok", idx, label);
    end else begin
      n_fail++;
      $display("case %0d %s failed", idx, label);
    end
  endtask

  task automatic run_case(input int idx);
    logic [31:0] rdata;
    logic        err;
    logic [31:0] port;
    case_err = 0;
    case (case_op[idx])
      "W": begin
        apb_access(1'b1, case_addr[idx], case_data[idx], rdata, err);
        if (err !== case_err_exp[idx]) begin
          $display("mismatch at %0t: write pslverr %0b expected %0b",
                   $time, err, case_err_exp[idx]);
          case_err++;
        end
      end
      "R": begin
        apb_access(1'b0, case_addr[idx], 32'h0, rdata, err);
        if (rdata !== case_exp[idx]) begin
          $display("mismatch at %0t: read %03h got %08h expected %08h",
                   $time, case_addr[idx][11:0], rdata, case_exp[idx]);
          case_err++;
        end
        if (err !== case_err_exp[idx]) begin
          $display("mismatch at %0t: read pslverr %0b expected %0b",
                   $time, err, case_err_exp[idx]);
          case_err++;
        end
      end
      "P": begin
        @(negedge clk_i);
        gpio_in_i = case_data[idx][GPIO_WIDTH-1:0];
      end
      "S": begin
        repeat (case_data[idx]) @(negedge clk_i);
        case (case_addr[idx])
          32'd0:   port = gpio_out_o;
          32'd1:   port = gpio_dir_o;
          32'd2:   port = {{(APB_DATA_WIDTH-NUM_EVENTS){1'b0}}, irq_o};
          32'd3:   port = boot_addr_o;
          32'd4:   port = pad_mux_o;
          default: begin
            port = case_exp[idx];
            $display("error: case %0d names no known output port", idx);
            case_err++;
          end
        endcase
        if (port !== case_exp[idx]) begin
          $display("mismatch at %0t: port %0d got %08h expected %08h",
                   $time, case_addr[idx], port, case_exp[idx]);
          case_err++;
        end
      end
      default: begin
        $display("error: case %0d has an unknown operation", idx);
        case_err++;
      end
    endcase
    record_result(idx, $sformatf("%s %03h", case_op[idx], case_addr[idx][11:0]));
  endtask

  // random word written, read back and seen on the pin side
  task automatic random_pair(input int idx, input logic to_soc);
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] port;
    logic        err;
    case_err = 0;
    wdata = $random(seed);
    addr  = to_soc ? {20'h0, SLV_SOC, SOC_PAD_MUX, 2'b00} : {20'h0, SLV_GPIO, GPIO_OUT, 2'b00};
    apb_access(1'b1, addr, wdata, rdata, err);
    if (err !== 1'b0) begin
      $display("mismatch at %0t: random write gave pslverr", $time);
      case_err++;
    end
    apb_access(1'b0, addr, 32'h0, rdata, err);
    if (rdata !== wdata || err !== 1'b0) begin
      $display("mismatch at %0t: read back %08h err %0b expected %08h",
               $time, rdata, err, wdata);
      case_err++;
    end
    port = to_soc ? pad_mux_o : gpio_out_o;
    if (port !== wdata) begin
      $display("mismatch at %0t: output port %08h expected %08h", $time, port, wdata);
      case_err++;
    end
    record_result(idx, to_soc ? "random pad_mux" : "random gpio_out");
  endtask

  ////////////////////////////////////////////////////////////
  // main flow
  ////////////////////////////////////////////////////////////
  initial begin
    int          fd;
    int          code;
    logic [7:0]  tok;
    logic [8*128-1:0] rest;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    logic [31:0] f_err;
    rst_n_i   = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    gpio_in_i = '0;

    fd = $fopen("verification/periph_cases.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open verification/periph_cases.txt");
      load_err++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(rest, fd);   // comment line
        end else begin
          code = $fscanf(fd, " %h %h %h %h", f_addr, f_data, f_exp, f_err);
          if (code != 4 || n_cases >= MAX_CASES) begin
            $display("error: bad or extra line after case %0d in cases file", n_cases);
            load_err++;
          end else begin
            case_op[n_cases]      = tok;
            case_addr[n_cases]    = f_addr;
            case_data[n_cases]    = f_data;
            case_exp[n_cases]     = f_exp;
            case_err_exp[n_cases] = f_err[0];
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 64 * (n_cases + 2 * N_RAND) + 200;

    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    for (int k = 0; k < 2 * N_RAND; k++) begin
      random_pair(n_cases + k, k[0]);
    end

    $display("tests %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && load_err == 0 && n_cases > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/periph_top.sv
// APB peripheral subsystem top
`default_nettype none

module periph_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // APB completer port
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  periph_pkg::apb_addr_t             paddr_i,
  input  periph_pkg::apb_data_t             pwdata_i,
  output periph_pkg::apb_data_t             prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // pins and sideband
  input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_dir_o,
  output logic [periph_pkg::NUM_EVENTS-1:0] irq_o,
  output periph_pkg::apb_data_t             boot_addr_o,
  output periph_pkg::apb_data_t             pad_mux_o
);
  import periph_pkg::*;

  logic                  gpio_event;
  logic                  timer_match;
  logic [NUM_EVENTS-1:0] events;

  apb_if gpio_bus ();
  apb_if timer_bus ();
  apb_if event_bus ();
  apb_if soc_bus ();

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  apb_decoder i_apb_decoder (
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .gpio_bus  (gpio_bus.requester),
    .timer_bus (timer_bus.requester),
    .event_bus (event_bus.requester),
    .soc_bus   (soc_bus.requester)
  );

  ////////////////////////////////////////////////////////////
  // peripherals
  ////////////////////////////////////////////////////////////
  apb_gpio i_apb_gpio (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (gpio_bus.completer),
    .gpio_in_i    (gpio_in_i),
    .gpio_out_o   (gpio_out_o),
    .gpio_dir_o   (gpio_dir_o),
    .gpio_event_o (gpio_event)
  );

  apb_timer i_apb_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (timer_bus.completer),
    .match_o (timer_match)
  );

  apb_soc_ctrl i_apb_soc_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (soc_bus.completer),
    .boot_addr_o (boot_addr_o),
    .pad_mux_o   (pad_mux_o)
  );

  // event lines by index
  assign events[EVT_GPIO]  = gpio_event;
  assign events[EVT_TIMER] = timer_match;

  apb_event_unit i_apb_event_unit (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .bus      (event_bus.completer),
    .events_i (events),
    .irq_o    (irq_o)
  );

endmodule

`default_nettype wire

// File: design/apb_soc_ctrl.sv
// SoC control with boot address and pad mux
`default_nettype none

module apb_soc_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  apb_if.completer              bus,
  output periph_pkg::apb_data_t boot_addr_o,
  output periph_pkg::apb_data_t pad_mux_o
);
  import periph_pkg::*;

  apb_data_t boot_addr_q;
  apb_data_t pad_mux_q;
  reg_ofs_t  ofs;
  logic      wr_en;
  logic      ofs_ok;

  assign ofs   = bus.paddr[REG_OFFSET_MSB:REG_OFFSET_LSB];
  assign wr_en = bus.psel & bus.penable & bus.pwrite;

  always_comb begin
    bus.prdata = '0;
    ofs_ok     = 1'b1;
    case (ofs)
      SOC_BOOT_ADDR: bus.prdata = boot_addr_q;
      SOC_PAD_MUX:   bus.prdata = pad_mux_q;
      default:       ofs_ok = 1'b0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = bus.psel & bus.penable & ~ofs_ok;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= BOOT_ADDR_RESET;
      pad_mux_q   <= '0;
    end else begin
      if (wr_en && ofs == SOC_BOOT_ADDR) boot_addr_q <= bus.pwdata;
      if (wr_en && ofs == SOC_PAD_MUX)   pad_mux_q   <= bus.pwdata;
    end
  end

  assign boot_addr_o = boot_addr_q;
  assign pad_mux_o   = pad_mux_q;

endmodule

`default_nettype wire

// File: design/apb_event_unit.sv
// event unit turning pending and mask into interrupts
`default_nettype none

module apb_event_unit (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  apb_if.completer                          bus,
  input  logic [periph_pkg::NUM_EVENTS-1:0] events_i,
  output logic [periph_pkg::NUM_EVENTS-1:0] irq_o
);
  import periph_pkg::*;

  logic [NUM_EVENTS-1:0] mask_q;
  logic [NUM_EVENTS-1:0] pending_q;
  logic [NUM_EVENTS-1:0] clr;

  reg_ofs_t ofs;
  logic     wr_en;
  logic     ofs_ok;

  assign ofs   = bus.paddr[REG_OFFSET_MSB:REG_OFFSET_LSB];
  assign wr_en = bus.psel & bus.penable & bus.pwrite;

  // write one to clear on EVT_PENDING
  assign clr = (wr_en && ofs == EVT_PENDING) ? bus.pwdata[NUM_EVENTS-1:0] : '0;

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////
  always_comb begin
    bus.prdata = '0;
    ofs_ok     = 1'b1;
    case (ofs)
      EVT_MASK:    bus.prdata = apb_data_t'(mask_q);
      EVT_PENDING: bus.prdata = apb_data_t'(pending_q);
      default:     ofs_ok = 1'b0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = bus.psel & bus.penable & ~ofs_ok;

  ////////////////////////////////////////////////////////////
  // pending and mask
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_q    <= '0;
      pending_q <= '0;
    end else begin
      // incoming event wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr) | events_i;
      if (wr_en && ofs == EVT_MASK) begin
        mask_q <= bus.pwdata[NUM_EVENTS-1:0];
      end
    end
  end

  assign irq_o = pending_q & mask_q;   // no output flop

endmodule

`default_nettype wire

// File: design/apb_timer.sv
// compare-match timer
`default_nettype none

module apb_timer (
  input  logic     clk_i,
  input  logic     rst_n_i,
  apb_if.completer bus,
  output logic     match_o
);
  import periph_pkg::*;

  apb_data_t count_q;
  apb_data_t cmp_q;
  logic      en_q;
  logic      match_q;

  reg_ofs_t ofs;
  logic     wr_en;
  logic     ofs_ok;
  logic     hit;

  assign ofs   = bus.paddr[REG_OFFSET_MSB:REG_OFFSET_LSB];
  assign wr_en = bus.psel & bus.penable & bus.pwrite;
  assign hit   = en_q & (count_q == cmp_q);  // wrap condition

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////
  always_comb begin
    bus.prdata = '0;
    ofs_ok     = 1'b1;
    case (ofs)
      TIMER_COUNT: bus.prdata = count_q;
      TIMER_CTRL:  bus.prdata = {{(APB_DATA_WIDTH-1){1'b0}}, en_q};
      TIMER_CMP:   bus.prdata = cmp_q;
      default:     ofs_ok = 1'b0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = bus.psel & bus.penable & ~ofs_ok;

  ////////////////////////////////////////////////////////////
  // counter and compare
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      cmp_q   <= '1;     // free-running until software sets a compare
      en_q    <= 1'b0;
      match_q <= 1'b0;
    end else begin
      match_q <= hit;    // one-cycle pulse with count zero after it
      if (wr_en && ofs == TIMER_COUNT) begin
        count_q <= bus.pwdata;  // software load beats counting
      end else if (hit) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && ofs == TIMER_CTRL) en_q  <= bus.pwdata[0];
      if (wr_en && ofs == TIMER_CMP)  cmp_q <= bus.pwdata;
    end
  end

  assign match_o = match_q;

endmodule

`default_nettype wire

// File: design/apb_gpio.sv
// GPIO with rising-edge interrupts
`default_nettype none

module apb_gpio (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  apb_if.completer                          bus,
  input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_dir_o,
  output logic                              gpio_event_o
);
  import periph_pkg::*;

  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] inten_q;
  logic [GPIO_WIDTH-1:0] status_q;
  logic [GPIO_WIDTH-1:0] sync1_q;   // first sync stage
  logic [GPIO_WIDTH-1:0] sync2_q;   // GPIO_IN value
  logic [GPIO_WIDTH-1:0] prev_q;    // sync2 delayed for edge detect
  logic [GPIO_WIDTH-1:0] rise;

  reg_ofs_t ofs;
  logic     wr_en;
  logic     rd_en;
  logic     ofs_ok;

  assign ofs   = bus.paddr[REG_OFFSET_MSB:REG_OFFSET_LSB];
  assign wr_en = bus.psel & bus.penable & bus.pwrite;
  assign rd_en = bus.psel & bus.penable & ~bus.pwrite;
  assign rise  = sync2_q & ~prev_q & inten_q;  // enabled pins only

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////
  always_comb begin
    bus.prdata = '0;
    ofs_ok     = 1'b1;
    case (ofs)
      GPIO_DIR:       bus.prdata = apb_data_t'(dir_q);
      GPIO_IN:        bus.prdata = apb_data_t'(sync2_q);
      GPIO_OUT:       bus.prdata = apb_data_t'(out_q);
      GPIO_INTEN:     bus.prdata = apb_data_t'(inten_q);
      GPIO_INTSTATUS: bus.prdata = apb_data_t'(status_q);
      default:        ofs_ok = 1'b0;  // hole in the map
    endcase
  end

  assign bus.pready  = 1'b1;                       // zero wait
  assign bus.pslverr = bus.psel & bus.penable & ~ofs_ok;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      inten_q  <= '0;
      status_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && ofs == GPIO_DIR)   dir_q   <= bus.pwdata[GPIO_WIDTH-1:0];
      if (wr_en && ofs == GPIO_OUT)   out_q   <= bus.pwdata[GPIO_WIDTH-1:0];
      if (wr_en && ofs == GPIO_INTEN) inten_q <= bus.pwdata[GPIO_WIDTH-1:0];
      // clear on read but a new edge in the same cycle still lands
      if (rd_en && ofs == GPIO_INTSTATUS) begin
        status_q <= rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  assign gpio_dir_o   = dir_q;
  assign gpio_out_o   = out_q;
  assign gpio_event_o = |status_q;   // any pending pin

endmodule

`default_nettype wire

// File: design/apb_decoder.sv
// APB address decoder
`default_nettype none

module apb_decoder (
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  apb_if.requester              gpio_bus,
  apb_if.requester              timer_bus,
  apb_if.requester              event_bus,
  apb_if.requester              soc_bus
);
  import periph_pkg::*;

  slv_idx_t slv_idx;

  assign slv_idx = paddr_i[SLAVE_SEL_MSB:SLAVE_SEL_LSB];

  ////////////////////////////////////////////////////////////
  // request fan-out with psel only on the addressed slave
  ////////////////////////////////////////////////////////////
  assign gpio_bus.psel    = psel_i & (slv_idx == SLV_GPIO);
  assign gpio_bus.penable = penable_i;
  assign gpio_bus.pwrite  = pwrite_i;
  assign gpio_bus.paddr   = paddr_i;
  assign gpio_bus.pwdata  = pwdata_i;

  assign timer_bus.psel    = psel_i & (slv_idx == SLV_TIMER);
  assign timer_bus.penable = penable_i;
  assign timer_bus.pwrite  = pwrite_i;
  assign timer_bus.paddr   = paddr_i;
  assign timer_bus.pwdata  = pwdata_i;

  assign event_bus.psel    = psel_i & (slv_idx == SLV_EVENT);
  assign event_bus.penable = penable_i;
  assign event_bus.pwrite  = pwrite_i;
  assign event_bus.paddr   = paddr_i;
  assign event_bus.pwdata  = pwdata_i;

  assign soc_bus.psel    = psel_i & (slv_idx == SLV_SOC);
  assign soc_bus.penable = penable_i;
  assign soc_bus.pwrite  = pwrite_i;
  assign soc_bus.paddr   = paddr_i;
  assign soc_bus.pwdata  = pwdata_i;

  ////////////////////////////////////////////////////////////
  // response mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    // unmapped slave answers here with an error in the access phase
    prdata_o  = '0;
    pready_o  = 1'b1;
    pslverr_o = psel_i & penable_i;
    case (slv_idx)
      SLV_GPIO: begin
        prdata_o  = gpio_bus.prdata;
        pready_o  = gpio_bus.pready;
        pslverr_o = gpio_bus.pslverr;
      end
      SLV_TIMER: begin
        prdata_o  = timer_bus.prdata;
        pready_o  = timer_bus.pready;
        pslverr_o = timer_bus.pslverr;
      end
      SLV_EVENT: begin
        prdata_o  = event_bus.prdata;
        pready_o  = event_bus.pready;
        pslverr_o = event_bus.pslverr;
      end
      SLV_SOC: begin
        prdata_o  = soc_bus.prdata;
        pready_o  = soc_bus.pready;
        pslverr_o = soc_bus.pslverr;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/apb_if.sv
// APB link between decoder and peripherals
`default_nettype none

interface apb_if;
  import periph_pkg::*;

  // request driven by the decoder
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;

  // response driven by one peripheral
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

// File: design/periph_pkg.sv
// APB peripheral subsystem
// shared widths, address map and register offsets
`default_nettype none

package periph_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////
  localparam int SLAVE_SEL_MSB  = 11;   // slave index field
  localparam int SLAVE_SEL_LSB  = 8;
  localparam int REG_OFFSET_MSB = 7;    // word offset field
  localparam int REG_OFFSET_LSB = 2;

  typedef logic [SLAVE_SEL_MSB-SLAVE_SEL_LSB:0]   slv_idx_t;
  typedef logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] reg_ofs_t;

  localparam slv_idx_t SLV_GPIO  = 4'd0;
  localparam slv_idx_t SLV_TIMER = 4'd1;
  localparam slv_idx_t SLV_EVENT = 4'd2;
  localparam slv_idx_t SLV_SOC   = 4'd3;  // 4..15 unmapped

  // gpio
  localparam int       GPIO_WIDTH     = 32;
  localparam reg_ofs_t GPIO_DIR       = 6'd0;
  localparam reg_ofs_t GPIO_IN        = 6'd1;
  localparam reg_ofs_t GPIO_OUT       = 6'd2;
  localparam reg_ofs_t GPIO_INTEN     = 6'd3;
  localparam reg_ofs_t GPIO_INTSTATUS = 6'd4;  // clear on read

  // timer
  localparam reg_ofs_t TIMER_COUNT = 6'd0;
  localparam reg_ofs_t TIMER_CTRL  = 6'd1;  // bit 0 enable
  localparam reg_ofs_t TIMER_CMP   = 6'd2;

  // event unit
  localparam reg_ofs_t EVT_MASK    = 6'd0;
  localparam reg_ofs_t EVT_PENDING = 6'd1;  // write one to clear

  // soc control
  localparam reg_ofs_t  SOC_BOOT_ADDR   = 6'd0;
  localparam reg_ofs_t  SOC_PAD_MUX     = 6'd1;
  localparam apb_data_t BOOT_ADDR_RESET = 32'h0000_8000;

  ////////////////////////////////////////////////////////////
  // event lines
  ////////////////////////////////////////////////////////////
  localparam int NUM_EVENTS = 2;

  typedef enum logic [0:0] {
    EVT_GPIO  = 1'b0,
    EVT_TIMER = 1'b1
  } evt_idx_e;

endpackage

`default_nettype wire
